// File: Makefile
# Verilator lint and simulation of the pointwise convolution kernel

VERILATOR ?= verilator
TOP       ?= tb_pw_conv
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

# Status comes from the search for the pass message
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: common/param_wr_if.sv
// ===============================================
// Parameter write port
// Weight and bias entry writes from the intake
// into the engine memories
// ===============================================
`timescale 1ns/1ns

interface param_wr_if
    import pw_pkg::*;
();

    logic               wt_we;
    logic               bias_we;
    logic [MEM_AW-1:0]  index;
    // Weights in the low 64 bits, biases use all 128
    logic [PARAM_W-1:0] data;

    modport source (output wt_we, output bias_we, output index, output data);

    modport sink (input wt_we, input bias_we, input index, input data);

endinterface

// File: common/pixel_beat_if.sv
// ===============================================
// Pixel beat port
// Accepted pixel beats with memory index and the
// counted last flag
// ===============================================
`timescale 1ns/1ns

interface pixel_beat_if
    import pw_pkg::*;
();

    logic               valid;
    // Eight signed int8 lanes, lane i in byte i
    logic [PIXEL_W-1:0] data;
    logic [MEM_AW-1:0]  index;
    logic               last;

    modport source (output valid, output data, output index, output last);

    modport sink (input valid, input data, input index, input last);

endinterface

// File: common/pw_pkg.sv
// ===============================================
// Pointwise convolution shared definitions
// Stream widths, memory sizing, quantize widths
// and the kernel control states
// ===============================================

package pw_pkg;

    // Stream widths
    localparam int PARAM_W     = 128;
    localparam int PIXEL_W     = 64;
    localparam int LANES       = 8;
    localparam int PARAM_BYTES = PARAM_W / 8;
    localparam int PIXEL_BYTES = PIXEL_W / 8;
    localparam int SIZE_W      = 32;

    // Lane layout inside weight and bias entries
    localparam int LANE_W      = 8;
    localparam int BIAS_LANE_W = 16;
    localparam int WT_W        = LANES * LANE_W;

    // Parameter memories, index taken from the byte count
    localparam int MEM_DEPTH     = 16;
    localparam int MEM_AW        = 4;
    localparam int PARAM_IDX_LSB = 4;
    localparam int PIXEL_IDX_LSB = 3;

    // Datapath reset length
    localparam int RESET_CYCLES = 8;
    localparam int RST_CNT_W    = 3;

    // Requantize arithmetic
    localparam int QM_W    = 16;
    localparam int QN_W    = 5;
    localparam int ACC_W   = 17;
    localparam int SCALE_W = ACC_W + QM_W + 1;
    localparam int Q_MAX   = 127;
    localparam int Q_MIN   = -128;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RESET,
        ST_LOAD_WEIGHTS,
        ST_LOAD_BIAS,
        ST_START,
        ST_PROCESS,
        ST_DONE
    } kernel_state_t;

endpackage

// File: control/kernel_fsm.sv
// ===============================================
// Kernel control FSM
// Start edge, datapath reset, parameter loads,
// processing and the ap_idle / ap_done handshake
// ===============================================
`timescale 1ns/1ns

module kernel_fsm
    import pw_pkg::*;
(
    input  logic          ap_clk,
    input  logic          areset,
    input  logic          ap_start,
    input  logic          wt_loaded,
    input  logic          bias_loaded,
    input  logic          out_last_seen,
    output kernel_state_t state,
    output logic          datapath_rst,
    output logic          ap_idle,
    output logic          ap_done
);

    kernel_state_t        state_next;
    logic                 ap_start_r;
    logic                 start_pulse;
    logic [RST_CNT_W-1:0] rst_cnt;
    logic                 rst_last;

    // Rising edge of ap_start
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            ap_start_r <= 1'b0;
        end else begin
            ap_start_r <= ap_start;
        end
    end

    assign start_pulse = ap_start & ~ap_start_r;

    // ===============================================
    // Reset state timing
    // ===============================================
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            rst_cnt <= '0;
        end else if (state == ST_RESET) begin
            rst_cnt <= rst_cnt + 1'b1;
        end else begin
            rst_cnt <= '0;
        end
    end

    assign rst_last = (rst_cnt == RST_CNT_W'(RESET_CYCLES - 1));

    // Aligned with the reset state; also held through areset
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            datapath_rst <= 1'b1;
        end else begin
            datapath_rst <= (state_next == ST_RESET);
        end
    end

    // ===============================================
    // State sequencing
    // ===============================================
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start_pulse) begin
                    state_next = ST_RESET;
                end
            end
            ST_RESET: begin
                if (rst_last) begin
                    state_next = ST_LOAD_WEIGHTS;
                end
            end
            ST_LOAD_WEIGHTS: begin
                if (wt_loaded) begin
                    state_next = ST_LOAD_BIAS;
                end
            end
            ST_LOAD_BIAS: begin
                if (bias_loaded) begin
                    state_next = ST_START;
                end
            end
            // One cycle only
            ST_START: state_next = ST_PROCESS;
            ST_PROCESS: begin
                // Final output beat leaves the engine
                if (out_last_seen) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: state_next = ST_IDLE;
            default: state_next = ST_IDLE;
        endcase
    end

    // Idle drops on a start edge, returns with the done pulse
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            ap_idle <= 1'b1;
            ap_done <= 1'b0;
        end else begin
            ap_done <= (state == ST_DONE);
            if (state == ST_DONE) begin
                ap_idle <= 1'b1;
            end else if ((state == ST_IDLE) && start_pulse) begin
                ap_idle <= 1'b0;
            end
        end
    end

endmodule

// File: list.f
common/pw_pkg.sv
common/param_wr_if.sv
common/pixel_beat_if.sv
control/kernel_fsm.sv
logic/stream_intake.sv
pointwise/pointwise_engine.sv
logic/pw_conv_top.sv
sim/pw_conv_props.sv
sim/tb_pw_conv.sv

// File: logic/pw_conv_top.sv
// ===============================================
// Pointwise convolution kernel top level
// Control FSM, stream intake and engine on plain
// valid/ready and strobe ports
// ===============================================
`timescale 1ns/1ns

module pw_conv_top
    import pw_pkg::*;
(
    input  logic               ap_clk,
    input  logic               areset,
    input  logic               ap_start,
    input  logic [SIZE_W-1:0]  num_weights,
    input  logic [SIZE_W-1:0]  num_bias,
    input  logic [SIZE_W-1:0]  num_pixels,
    input  logic [QM_W-1:0]    cfg_quant_m,
    input  logic [QN_W-1:0]    cfg_quant_n,
    input  logic               cfg_use_relu,
    input  logic [PARAM_W-1:0] param_data,
    input  logic               param_valid,
    input  logic [PIXEL_W-1:0] pixel_data,
    input  logic               pixel_valid,
    output logic               ap_idle,
    output logic               ap_done,
    output logic               param_ready,
    output logic               pixel_ready,
    output logic [PIXEL_W-1:0] out_data,
    output logic               out_valid,
    output logic               out_last
);

    kernel_state_t state;
    logic          datapath_rst;
    logic          wt_loaded;
    logic          bias_loaded;

    param_wr_if   u_wr_if ();
    pixel_beat_if u_pix_if ();

    // Control
    kernel_fsm u_kernel_fsm (
        .ap_clk        (ap_clk),
        .areset        (areset),
        .ap_start      (ap_start),
        .wt_loaded     (wt_loaded),
        .bias_loaded   (bias_loaded),
        .out_last_seen (out_last),
        .state         (state),
        .datapath_rst  (datapath_rst),
        .ap_idle       (ap_idle),
        .ap_done       (ap_done)
    );

    // Input side
    stream_intake u_stream_intake (
        .ap_clk       (ap_clk),
        .areset       (areset),
        .datapath_rst (datapath_rst),
        .state        (state),
        .num_weights  (num_weights),
        .num_bias     (num_bias),
        .num_pixels   (num_pixels),
        .param_data   (param_data),
        .param_valid  (param_valid),
        .pixel_data   (pixel_data),
        .pixel_valid  (pixel_valid),
        .param_ready  (param_ready),
        .pixel_ready  (pixel_ready),
        .wt_loaded    (wt_loaded),
        .bias_loaded  (bias_loaded),
        .wr           (u_wr_if.source),
        .pix          (u_pix_if.source)
    );

    // Processing and output side
    pointwise_engine u_pointwise_engine (
        .ap_clk       (ap_clk),
        .datapath_rst (datapath_rst),
        .cfg_quant_m  (cfg_quant_m),
        .cfg_quant_n  (cfg_quant_n),
        .cfg_use_relu (cfg_use_relu),
        .wr           (u_wr_if.sink),
        .pix          (u_pix_if.sink),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_last     (out_last)
    );

endmodule

// File: logic/stream_intake.sv
// ===============================================
// Stream intake
// Accepts parameter and pixel beats, counts bytes
// per phase and flags phase completion
// ===============================================
`timescale 1ns/1ns

module stream_intake
    import pw_pkg::*;
(
    input  logic               ap_clk,
    input  logic               areset,
    input  logic               datapath_rst,
    input  kernel_state_t      state,
    input  logic [SIZE_W-1:0]  num_weights,
    input  logic [SIZE_W-1:0]  num_bias,
    input  logic [SIZE_W-1:0]  num_pixels,
    input  logic [PARAM_W-1:0] param_data,
    input  logic               param_valid,
    input  logic [PIXEL_W-1:0] pixel_data,
    input  logic               pixel_valid,
    output logic               param_ready,
    output logic               pixel_ready,
    output logic               wt_loaded,
    output logic               bias_loaded,
    param_wr_if.source         wr,
    pixel_beat_if.source       pix
);

    logic [SIZE_W-1:0] wt_bytes;
    logic [SIZE_W-1:0] bias_bytes;
    logic [SIZE_W-1:0] px_bytes;
    logic              param_fire;
    logic              pixel_fire;

    // Ready drops once the phase byte count is reached
    // A zero size never raises it at all
    assign param_ready = ((state == ST_LOAD_WEIGHTS) && (wt_bytes < num_weights)) ||
                         ((state == ST_LOAD_BIAS) && (bias_bytes < num_bias));
    assign pixel_ready = (state == ST_PROCESS) && (px_bytes < num_pixels);

    assign param_fire = param_valid & param_ready;
    assign pixel_fire = pixel_valid & pixel_ready;

    // ===============================================
    // Byte counters, cleared by the datapath reset
    // ===============================================
    always_ff @(posedge ap_clk) begin
        if (areset || datapath_rst) begin
            wt_bytes   <= '0;
            bias_bytes <= '0;
            px_bytes   <= '0;
        end else begin
            if (wr.wt_we) begin
                wt_bytes <= wt_bytes + SIZE_W'(PARAM_BYTES);
            end
            if (wr.bias_we) begin
                bias_bytes <= bias_bytes + SIZE_W'(PARAM_BYTES);
            end
            if (pixel_fire) begin
                px_bytes <= px_bytes + SIZE_W'(PIXEL_BYTES);
            end
        end
    end

    // Phase done levels, held until the next run
    always_ff @(posedge ap_clk) begin
        if (areset || datapath_rst) begin
            wt_loaded   <= 1'b0;
            bias_loaded <= 1'b0;
        end else begin
            if ((state == ST_LOAD_WEIGHTS) && (wt_bytes >= num_weights)) begin
                wt_loaded <= 1'b1;
            end
            if ((state == ST_LOAD_BIAS) && (bias_bytes >= num_bias)) begin
                bias_loaded <= 1'b1;
            end
        end
    end

    // Parameter steering, index wraps at MEM_DEPTH
    assign wr.wt_we   = param_fire && (state == ST_LOAD_WEIGHTS);
    assign wr.bias_we = param_fire && (state == ST_LOAD_BIAS);
    assign wr.index   = (state == ST_LOAD_BIAS) ? bias_bytes[PARAM_IDX_LSB +: MEM_AW] :
                                                  wt_bytes[PARAM_IDX_LSB +: MEM_AW];
    assign wr.data    = param_data;

    // Pixel beats with counted last
    assign pix.valid = pixel_fire;
    assign pix.data  = pixel_data;
    assign pix.index = px_bytes[PIXEL_IDX_LSB +: MEM_AW];
    assign pix.last  = pixel_fire && ((px_bytes + SIZE_W'(PIXEL_BYTES)) >= num_pixels);

endmodule

// File: pointwise/pointwise_engine.sv
// ===============================================
// Pointwise engine
// Weight and bias memories and a three stage
// multiply, requantize and saturate pipeline
// ===============================================
`timescale 1ns/1ns

module pointwise_engine
    import pw_pkg::*;
(
    input  logic               ap_clk,
    input  logic               datapath_rst,
    input  logic [QM_W-1:0]    cfg_quant_m,
    input  logic [QN_W-1:0]    cfg_quant_n,
    input  logic               cfg_use_relu,
    param_wr_if.sink           wr,
    pixel_beat_if.sink         pix,
    output logic [PIXEL_W-1:0] out_data,
    output logic               out_valid,
    output logic               out_last
);

    logic [WT_W-1:0]           wt_mem   [MEM_DEPTH];
    logic [PARAM_W-1:0]        bias_mem [MEM_DEPTH];

    logic                      s1_valid;
    logic                      s1_last;
    logic [PIXEL_W-1:0]        s1_pix;
    logic [WT_W-1:0]           s1_wt;
    logic [PARAM_W-1:0]        s1_bias;

    logic                      s2_valid;
    logic                      s2_last;
    logic signed [ACC_W-1:0]   acc_next [LANES];
    logic signed [ACC_W-1:0]   s2_acc   [LANES];

    logic signed [SCALE_W-1:0] scaled   [LANES];
    logic signed [SCALE_W-1:0] shifted  [LANES];
    logic [PIXEL_W-1:0]        quant_next;

    // ===============================================
    // Parameter memories
    // ===============================================
    always_ff @(posedge ap_clk) begin
        if (wr.wt_we) begin
            // Only the low 64 bits carry weights
            wt_mem[wr.index] <= wr.data[WT_W-1:0];
        end
        if (wr.bias_we) begin
            bias_mem[wr.index] <= wr.data;
        end
    end

    // ===============================================
    // Valid and last alongside the data
    // ===============================================
    always_ff @(posedge ap_clk) begin
        if (datapath_rst) begin
            s1_valid  <= 1'b0;
            s1_last   <= 1'b0;
            s2_valid  <= 1'b0;
            s2_last   <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            s1_valid  <= pix.valid;
            s1_last   <= pix.valid & pix.last;
            s2_valid  <= s1_valid;
            s2_last   <= s1_last;
            out_valid <= s2_valid;
            out_last  <= s2_last;
        end
    end

    // Stage 1 fetches the entries at the beat index
    always_ff @(posedge ap_clk) begin
        s1_pix  <= pix.data;
        s1_wt   <= wt_mem[pix.index];
        s1_bias <= bias_mem[pix.index];
    end

    // Stage 2 accumulator per lane, all signed
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            acc_next[i] = $signed(s1_pix[i*LANE_W +: LANE_W]) *
                          $signed(s1_wt[i*LANE_W +: LANE_W]) +
                          $signed(s1_bias[i*BIAS_LANE_W +: BIAS_LANE_W]);
        end
    end

    always_ff @(posedge ap_clk) begin
        for (int i = 0; i < LANES; i++) begin
            s2_acc[i] <= acc_next[i];
        end
    end

    // Stage 3 scale, shift, optional ReLU, clamp to int8
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            // Multiplier is unsigned, widened with a zero sign bit
            scaled[i]  = s2_acc[i] * $signed({1'b0, cfg_quant_m});
            shifted[i] = scaled[i] >>> cfg_quant_n;
            if (cfg_use_relu && (shifted[i] < 0)) begin
                shifted[i] = '0;
            end
            if (shifted[i] > Q_MAX) begin
                quant_next[i*LANE_W +: LANE_W] = LANE_W'(Q_MAX);
            end else if (shifted[i] < Q_MIN) begin
                quant_next[i*LANE_W +: LANE_W] = LANE_W'(Q_MIN);
            end else begin
                quant_next[i*LANE_W +: LANE_W] = shifted[i][LANE_W-1:0];
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        out_data <= quant_next;
    end

endmodule

// File: sim/pw_conv_props.sv
// ==================================================
// Pointwise convolution kernel properties
// Control and stream rules bound into the top level
// ==================================================
`timescale 1ns/1ns

module pw_conv_props (
    input logic ap_clk,
    input logic areset,
    input logic ap_done,
    input logic ap_idle,
    input logic param_ready,
    input logic pixel_ready,
    input logic out_valid
);

    // Done is a one cycle pulse
    done_single: assert property (@(posedge ap_clk) disable iff (areset)
        ap_done |=> !ap_done)
        else $error("ap_done high on two cycles in a row");

    // Only one stream is open at a time
    ready_excl: assert property (@(posedge ap_clk) disable iff (areset)
        !(param_ready && pixel_ready))
        else $error("param_ready and pixel_ready high together");

    no_out_idle: assert property (@(posedge ap_clk) disable iff (areset)
        out_valid |-> !ap_idle)
        else $error("out_valid high while the kernel is idle");

endmodule

bind pw_conv_top pw_conv_props u_pw_conv_props (
    .ap_clk      (ap_clk),
    .areset      (areset),
    .ap_done     (ap_done),
    .ap_idle     (ap_idle),
    .param_ready (param_ready),
    .pixel_ready (pixel_ready),
    .out_valid   (out_valid)
);

// File: sim/tb_pw_conv.sv
// ==================================================
// Pointwise convolution kernel testbench
// Streams weights, biases and pixels into the DUT
// and checks every output beat against a reference
// ==================================================
`timescale 1ns/1ns

module tb_pw_conv
    import pw_pkg::*;
();

    // Seven runs of at most about 300 cycles each, with wide margin
    localparam int TIMEOUT_CYCLES = 8000;
    localparam int PARAM_BEATS    = 16;

    logic               ap_clk = 1'b0;
    logic               areset;
    logic               ap_start;
    logic [SIZE_W-1:0]  num_weights;
    logic [SIZE_W-1:0]  num_bias;
    logic [SIZE_W-1:0]  num_pixels;
    logic [QM_W-1:0]    cfg_quant_m;
    logic [QN_W-1:0]    cfg_quant_n;
    logic               cfg_use_relu;
    logic [PARAM_W-1:0] param_data;
    logic               param_valid;
    logic [PIXEL_W-1:0] pixel_data;
    logic               pixel_valid;
    logic               ap_idle;
    logic               ap_done;
    logic               param_ready;
    logic               pixel_ready;
    logic [PIXEL_W-1:0] out_data;
    logic               out_valid;
    logic               out_last;

    integer             seed = 32'hc37c;
    logic [WT_W-1:0]    wt_ref   [MEM_DEPTH];
    logic [PARAM_W-1:0] bias_ref [MEM_DEPTH];
    logic [PIXEL_W-1:0] exp_data_q [$];
    logic               exp_last_q [$];
    logic [PIXEL_W-1:0] exp_word;
    logic               exp_flag;
    int                 errors = 0;
    int                 checks = 0;
    int                 tests = 0;
    int                 out_count = 0;
    int                 done_count = 0;
    int                 since_last = 1000;
    int                 sat_hi = 0;
    int                 sat_lo = 0;
    int                 zero_lanes = 0;
    int                 cycle_cnt = 0;
    bit                 pix_low_check = 1'b0;
    bit                 param_low_check = 1'b0;

    pw_conv_top u_pw_conv_top (
        .ap_clk       (ap_clk),
        .areset       (areset),
        .ap_start     (ap_start),
        .num_weights  (num_weights),
        .num_bias     (num_bias),
        .num_pixels   (num_pixels),
        .cfg_quant_m  (cfg_quant_m),
        .cfg_quant_n  (cfg_quant_n),
        .cfg_use_relu (cfg_use_relu),
        .param_data   (param_data),
        .param_valid  (param_valid),
        .pixel_data   (pixel_data),
        .pixel_valid  (pixel_valid),
        .ap_idle      (ap_idle),
        .ap_done      (ap_done),
        .param_ready  (param_ready),
        .pixel_ready  (pixel_ready),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_last     (out_last)
    );

    always #20 ap_clk = ~ap_clk;

    // Run limit
    always @(posedge ap_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_level(input string name, input logic exp, input logic got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t ns: %s expected %0b, got %0b", $time, name, exp, got);
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Check failed at %0t ns: %s", $time, what);
        end
    endtask

    // ==================================================
    // Reference model of the pointwise requantize rule
    // ==================================================
    function automatic logic [PIXEL_W-1:0] expected_beat(input logic [PIXEL_W-1:0] px,
                                                         input int idx);
        logic [PIXEL_W-1:0] res;
        longint             acc;
        longint             val;
        for (int i = 0; i < LANES; i++) begin
            acc = longint'($signed(px[i*LANE_W +: LANE_W])) *
                  longint'($signed(wt_ref[idx][i*LANE_W +: LANE_W])) +
                  longint'($signed(bias_ref[idx][i*BIAS_LANE_W +: BIAS_LANE_W]));
            // Unsigned multiplier, then arithmetic shift
            val = (acc * longint'(cfg_quant_m)) >>> cfg_quant_n;
            if (cfg_use_relu && (val < 0)) begin
                val = 0;
            end
            if (val > 127) begin
                val = 127;
            end else if (val < -128) begin
                val = -128;
            end
            res[i*LANE_W +: LANE_W] = val[7:0];
        end
        return res;
    endfunction

    // Parameter source, random gaps, data held until accepted
    task automatic send_params(input int beats, input bit is_bias);
        logic [PARAM_W-1:0] beat;
        int                 gap;
        bit                 fired;
        for (int k = 0; k < beats; k++) begin
            beat = {$random(seed), $random(seed), $random(seed), $random(seed)};
            gap  = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge ap_clk);
                #2;
            end
            param_data  = beat;
            param_valid = 1'b1;
            fired = 1'b0;
            while (!fired) begin
                @(negedge ap_clk);
                fired = param_valid && param_ready;
                if (pix_low_check) begin
                    check_level("pixel_ready", 1'b0, pixel_ready);
                end
                @(posedge ap_clk);
                #2;
            end
            if (is_bias) begin
                bias_ref[k % MEM_DEPTH] = beat;
            end else begin
                wt_ref[k % MEM_DEPTH] = beat[WT_W-1:0];
            end
            param_valid = 1'b0;
        end
    endtask

    // Pixel source, expected beat queued on each transfer
    task automatic send_pixels(input int beats);
        logic [PIXEL_W-1:0] beat;
        int                 gap;
        bit                 fired;
        for (int k = 0; k < beats; k++) begin
            beat = {$random(seed), $random(seed)};
            gap  = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge ap_clk);
                #2;
            end
            pixel_data  = beat;
            pixel_valid = 1'b1;
            fired = 1'b0;
            while (!fired) begin
                @(negedge ap_clk);
                fired = pixel_valid && pixel_ready;
                if (param_low_check) begin
                    check_level("param_ready", 1'b0, param_ready);
                end
                if (fired) begin
                    exp_data_q.push_back(expected_beat(beat, k % MEM_DEPTH));
                    exp_last_q.push_back(k == beats - 1);
                end
                @(posedge ap_clk);
                #2;
            end
            pixel_valid = 1'b0;
        end
    endtask

    // ==================================================
    // Output compare and done timing monitor
    // ==================================================
    always @(negedge ap_clk) begin
        if (out_valid && out_last) begin
            since_last = 0;
        end else begin
            since_last++;
        end
        if (out_valid) begin
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("Output beat at %0t ns with no accepted pixel beat behind it", $time);
            end else begin
                exp_word = exp_data_q.pop_front();
                exp_flag = exp_last_q.pop_front();
                checks++;
                assert (out_data === exp_word) else begin
                    errors++;
                    $display("** Error at %0t ns: out_data expected %h, got %h",
                             $time, exp_word, out_data);
                end
                check_level("out_last", exp_flag, out_last);
                out_count++;
                for (int i = 0; i < LANES; i++) begin
                    if (out_data[i*LANE_W +: LANE_W] == 8'h7f) sat_hi++;
                    if (out_data[i*LANE_W +: LANE_W] == 8'h80) sat_lo++;
                    if (out_data[i*LANE_W +: LANE_W] == 8'h00) zero_lanes++;
                end
            end
        end
        if (ap_done) begin
            done_count++;
            expect_true(since_last == 2, "ap_done not two cycles after the last output beat");
            check_level("ap_idle", 1'b1, ap_idle);
        end
    end

    // One kernel run; offer_idle keeps the idle stream busy to probe the ready levels
    task automatic run_kernel(input int px_bytes, input int m, input int n,
                              input bit relu, input bit offer_idle);
        int beats;
        int outs_before;
        int dones_before;
        beats        = (px_bytes + PIXEL_BYTES - 1) / PIXEL_BYTES;
        outs_before  = out_count;
        dones_before = done_count;
        num_weights  = SIZE_W'(PARAM_BEATS * PARAM_BYTES);
        num_bias     = SIZE_W'(PARAM_BEATS * PARAM_BYTES);
        num_pixels   = SIZE_W'(px_bytes);
        cfg_quant_m  = QM_W'(m);
        cfg_quant_n  = QN_W'(n);
        cfg_use_relu = relu;
        ap_start = 1'b1;
        @(posedge ap_clk);
        #2;
        ap_start = 1'b0;
        check_level("ap_idle", 1'b0, ap_idle);
        if (offer_idle) begin
            pix_low_check = 1'b1;
            fork
                begin
                    send_params(PARAM_BEATS, 1'b0);
                    send_params(PARAM_BEATS, 1'b1);
                    pix_low_check   = 1'b0;
                    // Extra beat that the design must leave untouched
                    param_data      = {PARAM_W{1'b1}};
                    param_valid     = 1'b1;
                    param_low_check = 1'b1;
                end
                send_pixels(beats);
            join
        end else begin
            send_params(PARAM_BEATS, 1'b0);
            send_params(PARAM_BEATS, 1'b1);
            send_pixels(beats);
        end
        while (done_count == dones_before) begin
            @(posedge ap_clk);
        end
        #2;
        param_valid     = 1'b0;
        param_low_check = 1'b0;
        check_level("ap_idle", 1'b1, ap_idle);
        expect_true(out_count - outs_before == beats, "output beat count differs from input");
        expect_true(exp_data_q.size() == 0, "accepted pixel beats left without output");
    endtask

    task automatic end_test(input int num, input string name, input int err_before);
        tests++;
        $display("Test %0d %s: %s", num, name, (errors == err_before) ? "pass" : "fail");
    endtask

    initial begin
        int err_before;
        int hi_before;
        int lo_before;
        int zero_before;
        areset       = 1'b1;
        ap_start     = 1'b0;
        num_weights  = '0;
        num_bias     = '0;
        num_pixels   = '0;
        cfg_quant_m  = '0;
        cfg_quant_n  = '0;
        cfg_use_relu = 1'b0;
        param_data   = '0;
        param_valid  = 1'b0;
        pixel_data   = '0;
        pixel_valid  = 1'b0;
        repeat (16) @(posedge ap_clk);
        #2;
        areset = 1'b0;

        // Levels straight after reset
        err_before = errors;
        @(negedge ap_clk);
        check_level("ap_idle", 1'b1, ap_idle);
        check_level("ap_done", 1'b0, ap_done);
        check_level("param_ready", 1'b0, param_ready);
        check_level("pixel_ready", 1'b0, pixel_ready);
        check_level("out_valid", 1'b0, out_valid);
        @(posedge ap_clk);
        #2;
        end_test(0, "reset levels", err_before);

        err_before = errors;
        run_kernel(32 * PIXEL_BYTES, 3, 10, 1'b0, 1'b0);
        end_test(1, "full run", err_before);

        // Large multiplier, ReLU on then off
        err_before  = errors;
        hi_before   = sat_hi;
        lo_before   = sat_lo;
        zero_before = zero_lanes;
        run_kernel(32 * PIXEL_BYTES, 2000, 8, 1'b1, 1'b0);
        expect_true(sat_hi > hi_before, "no lane saturated at 127 with ReLU on");
        expect_true(zero_lanes > zero_before, "no negative lane clipped to 0 by ReLU");
        expect_true(sat_lo == lo_before, "lane at -128 with ReLU on");
        run_kernel(32 * PIXEL_BYTES, 2000, 8, 1'b0, 1'b0);
        expect_true(sat_lo > lo_before, "no lane saturated at -128 with ReLU off");
        end_test(2, "relu and saturation", err_before);

        err_before = errors;
        run_kernel(100, 5, 9, 1'b0, 1'b0);
        end_test(3, "partial last beat", err_before);

        err_before = errors;
        run_kernel(24 * PIXEL_BYTES, 7, 11, 1'b1, 1'b1);
        end_test(4, "ready gating", err_before);

        // Second run reloads all parameters
        err_before = errors;
        run_kernel(20 * PIXEL_BYTES, 4, 10, 1'b0, 1'b0);
        run_kernel(32 * PIXEL_BYTES, 6, 10, 1'b0, 1'b0);
        end_test(5, "back to back runs", err_before);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
